// ==== hw/id_pkg.sv ====
package id_pkg;

    localparam int XLEN    = 64;
    localparam int REG_AW  = 5;
    localparam int SHAMT_W = 6;  // rv64 shifts go up to 63

    // major opcodes
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP_IMM_W = 7'b0011011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_OP_W     = 7'b0111011;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;

    // op-imm, also used for op since the codes line up
    localparam logic [2:0] F3_ADDI  = 3'b000;
    localparam logic [2:0] F3_SLLI  = 3'b001;
    localparam logic [2:0] F3_SLTI  = 3'b010;
    localparam logic [2:0] F3_SLTIU = 3'b011;
    localparam logic [2:0] F3_XORI  = 3'b100;
    localparam logic [2:0] F3_SRI   = 3'b101;  // srli and srai
    localparam logic [2:0] F3_ORI   = 3'b110;
    localparam logic [2:0] F3_ANDI  = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LD  = 3'b011;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_LWU = 3'b110;

    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;
    localparam logic [2:0] F3_SD = 3'b011;

    localparam logic [2:0] F3_JALR = 3'b000;

    // 32-bit word ops, shared by op-imm-32 and op-32
    localparam logic [2:0] F3_ADDW  = 3'b000;  // addiw, addw, subw, mulw
    localparam logic [2:0] F3_SLLW  = 3'b001;
    localparam logic [2:0] F3_DIVW  = 3'b100;
    localparam logic [2:0] F3_SRW   = 3'b101;  // also divuw with m func7
    localparam logic [2:0] F3_REMW  = 3'b110;
    localparam logic [2:0] F3_REMUW = 3'b111;

    localparam logic [6:0] FUNC7_MULDIV = 7'b0000001;

    typedef union packed {
        struct packed {
            logic [6:0] func7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] func3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  func3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] func3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] func3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } inst_t;

endpackage

// ==== hw/imm_gen.sv ====
module imm_gen (
    input  id_pkg::inst_t                 inst_i,
    output logic [id_pkg::XLEN-1:0]       imm_i_o,
    output logic [id_pkg::XLEN-1:0]       imm_s_o,
    output logic [id_pkg::XLEN-1:0]       imm_b_o,
    output logic [id_pkg::XLEN-1:0]       imm_u_o,
    output logic [id_pkg::XLEN-1:0]       imm_j_o,
    output logic [id_pkg::SHAMT_W-1:0]    shamt_o
);

    // every format keeps its sign in bit 31
    assign imm_i_o = {{(id_pkg::XLEN-12){inst_i.i_fmt.imm_11_0[11]}}, inst_i.i_fmt.imm_11_0};

    assign imm_s_o = {{(id_pkg::XLEN-12){inst_i.s_fmt.imm_11_5[6]}},
                      inst_i.s_fmt.imm_11_5,
                      inst_i.s_fmt.imm_4_0};

    // branch targets are halfword aligned
    assign imm_b_o = {{(id_pkg::XLEN-13){inst_i.b_fmt.imm_12}},
                      inst_i.b_fmt.imm_12,
                      inst_i.b_fmt.imm_11,
                      inst_i.b_fmt.imm_10_5,
                      inst_i.b_fmt.imm_4_1,
                      1'b0};

    assign imm_u_o = {{(id_pkg::XLEN-32){inst_i.u_fmt.imm_31_12[19]}},
                      inst_i.u_fmt.imm_31_12,
                      12'b0};  // upper 20 bits only

    assign imm_j_o = {{(id_pkg::XLEN-21){inst_i.j_fmt.imm_20}},
                      inst_i.j_fmt.imm_20,
                      inst_i.j_fmt.imm_19_12,
                      inst_i.j_fmt.imm_11,
                      inst_i.j_fmt.imm_10_1,
                      1'b0};

    assign shamt_o = inst_i.i_fmt.imm_11_0[id_pkg::SHAMT_W-1:0];  // imm[5:0]

endmodule

// ==== hw/reg_file.sv ====
module reg_file (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic [id_pkg::REG_AW-1:0]   rs1_addr_i,
    input  logic [id_pkg::REG_AW-1:0]   rs2_addr_i,
    output logic [id_pkg::XLEN-1:0]     rs1_data_o,
    output logic [id_pkg::XLEN-1:0]     rs2_data_o,
    input  logic                        wb_wen_i,
    input  logic [id_pkg::REG_AW-1:0]   wb_addr_i,
    input  logic [id_pkg::XLEN-1:0]     wb_data_i
);

    localparam int NREG = 2 ** id_pkg::REG_AW;

    logic [id_pkg::XLEN-1:0] regs [1:NREG-1];  // no storage for x0

    logic wr_en;

    assign wr_en = wb_wen_i && (wb_addr_i != '0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_addr_i] <= wb_data_i;
        end
    end

    // x0 reads zero, a write landing this cycle wins over the array
    function automatic logic [id_pkg::XLEN-1:0] read_port(
        input logic [id_pkg::REG_AW-1:0] addr
    );
        logic [id_pkg::XLEN-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (wr_en && (wb_addr_i == addr)) begin
            data = wb_data_i;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    assign rs1_data_o = read_port(rs1_addr_i);
    assign rs2_data_o = read_port(rs2_addr_i);

    // the bypassed value must also be what the array keeps
    a_write_lands: assert property (@(posedge clk) disable iff (!rst_n_i)
        wr_en |=> regs[$past(wb_addr_i)] == $past(wb_data_i))
        else $error("reg_file: write-back data not stored");

endmodule

// ==== hw/inst_decode.sv ====
module inst_decode (
    input  logic                        clk,
    input  logic                        rst_n_i,

    input  logic                        inst_valid_i,
    input  id_pkg::inst_t               inst_i,
    input  logic [id_pkg::XLEN-1:0]     inst_addr_i,

    // from imm_gen
    input  logic [id_pkg::XLEN-1:0]     imm_i_i,
    input  logic [id_pkg::XLEN-1:0]     imm_s_i,
    input  logic [id_pkg::XLEN-1:0]     imm_b_i,
    input  logic [id_pkg::XLEN-1:0]     imm_u_i,
    input  logic [id_pkg::XLEN-1:0]     imm_j_i,
    input  logic [id_pkg::SHAMT_W-1:0]  shamt_i,

    // register file read port
    input  logic [id_pkg::XLEN-1:0]     rs1_data_i,
    input  logic [id_pkg::XLEN-1:0]     rs2_data_i,
    output logic [id_pkg::REG_AW-1:0]   rs1_addr_o,
    output logic [id_pkg::REG_AW-1:0]   rs2_addr_o,

    // to id/ex
    output logic                        ex_valid_o,
    output logic [id_pkg::XLEN-1:0]     ex_inst_addr_o,
    output logic [id_pkg::XLEN-1:0]     ex_op1_o,
    output logic [id_pkg::XLEN-1:0]     ex_op2_o,
    output logic [id_pkg::REG_AW-1:0]   ex_rd_addr_o,
    output logic                        ex_reg_wen_o,
    output logic [id_pkg::XLEN-1:0]     ex_base_addr_o,
    output logic [id_pkg::XLEN-1:0]     ex_offset_addr_o
);

    logic [6:0] opcode;
    logic [2:0] func3;
    logic       f3_ok;     // opcode known and func3 legal for it
    logic       reg_shift; // op shift that only uses rs2[5:0]

    logic [id_pkg::XLEN-1:0]   op1_nxt;
    logic [id_pkg::XLEN-1:0]   op2_nxt;
    logic [id_pkg::REG_AW-1:0] rd_nxt;
    logic                      wen_nxt;
    logic [id_pkg::XLEN-1:0]   base_nxt;
    logic [id_pkg::XLEN-1:0]   offset_nxt;

    assign opcode = inst_i.r_fmt.opcode;
    assign func3  = inst_i.r_fmt.func3;

    assign reg_shift = (func3 == id_pkg::F3_SLLI || func3 == id_pkg::F3_SRI) &&
                       (inst_i.r_fmt.func7 != id_pkg::FUNC7_MULDIV);

    always_comb begin
        case (opcode)
            id_pkg::OPC_OP_IMM, id_pkg::OPC_OP:
                f3_ok = func3 inside {id_pkg::F3_ADDI, id_pkg::F3_SLLI, id_pkg::F3_SLTI,
                                      id_pkg::F3_SLTIU, id_pkg::F3_XORI, id_pkg::F3_SRI,
                                      id_pkg::F3_ORI, id_pkg::F3_ANDI};
            id_pkg::OPC_OP_IMM_W:
                f3_ok = func3 inside {id_pkg::F3_ADDW, id_pkg::F3_SLLW, id_pkg::F3_SRW};
            id_pkg::OPC_OP_W:
                f3_ok = func3 inside {id_pkg::F3_ADDW, id_pkg::F3_SLLW, id_pkg::F3_DIVW,
                                      id_pkg::F3_SRW, id_pkg::F3_REMW, id_pkg::F3_REMUW};
            id_pkg::OPC_BRANCH:
                f3_ok = func3 inside {id_pkg::F3_BEQ, id_pkg::F3_BNE, id_pkg::F3_BLT,
                                      id_pkg::F3_BGE, id_pkg::F3_BLTU, id_pkg::F3_BGEU};
            id_pkg::OPC_LOAD:
                f3_ok = func3 inside {id_pkg::F3_LB, id_pkg::F3_LH, id_pkg::F3_LW,
                                      id_pkg::F3_LD, id_pkg::F3_LBU, id_pkg::F3_LHU,
                                      id_pkg::F3_LWU};
            id_pkg::OPC_STORE:
                f3_ok = func3 inside {id_pkg::F3_SB, id_pkg::F3_SH, id_pkg::F3_SW, id_pkg::F3_SD};
            id_pkg::OPC_JALR:
                f3_ok = (func3 == id_pkg::F3_JALR);
            id_pkg::OPC_JAL, id_pkg::OPC_LUI, id_pkg::OPC_AUIPC:
                f3_ok = 1'b1;  // no func3 field
            default:
                f3_ok = 1'b0;
        endcase
    end

    always_comb begin
        rs1_addr_o = '0;
        rs2_addr_o = '0;
        op1_nxt    = '0;
        op2_nxt    = '0;
        rd_nxt     = '0;
        wen_nxt    = 1'b0;
        base_nxt   = '0;
        offset_nxt = '0;
        if (f3_ok) begin
            case (opcode)
                id_pkg::OPC_OP_IMM, id_pkg::OPC_OP_IMM_W: begin
                    rs1_addr_o = inst_i.i_fmt.rs1;
                    op1_nxt    = rs1_data_i;
                    if (func3 == id_pkg::F3_SLLI || func3 == id_pkg::F3_SRI) begin
                        op2_nxt = {{(id_pkg::XLEN-id_pkg::SHAMT_W){1'b0}}, shamt_i};
                    end else begin
                        op2_nxt = imm_i_i;
                    end
                    rd_nxt  = inst_i.i_fmt.rd;
                    wen_nxt = 1'b1;
                end
                id_pkg::OPC_OP, id_pkg::OPC_OP_W: begin
                    rs1_addr_o = inst_i.r_fmt.rs1;
                    rs2_addr_o = inst_i.r_fmt.rs2;
                    op1_nxt    = rs1_data_i;
                    op2_nxt    = reg_shift ?
                        {{(id_pkg::XLEN-id_pkg::SHAMT_W){1'b0}}, rs2_data_i[id_pkg::SHAMT_W-1:0]} :
                        rs2_data_i;  // m ops want the whole divisor
                    rd_nxt     = inst_i.r_fmt.rd;
                    wen_nxt    = 1'b1;
                end
                id_pkg::OPC_BRANCH: begin
                    rs1_addr_o = inst_i.b_fmt.rs1;
                    rs2_addr_o = inst_i.b_fmt.rs2;
                    op1_nxt    = rs1_data_i;  // compared in ex
                    op2_nxt    = rs2_data_i;
                    base_nxt   = inst_addr_i;
                    offset_nxt = imm_b_i;
                end
                id_pkg::OPC_LOAD: begin
                    rs1_addr_o = inst_i.i_fmt.rs1;
                    op1_nxt    = rs1_data_i;
                    op2_nxt    = imm_i_i;
                    rd_nxt     = inst_i.i_fmt.rd;
                    wen_nxt    = 1'b1;
                    base_nxt   = rs1_data_i;
                    offset_nxt = imm_i_i;
                end
                id_pkg::OPC_STORE: begin
                    rs1_addr_o = inst_i.s_fmt.rs1;
                    rs2_addr_o = inst_i.s_fmt.rs2;
                    op2_nxt    = rs2_data_i;  // store data
                    base_nxt   = rs1_data_i;
                    offset_nxt = imm_s_i;
                end
                id_pkg::OPC_JAL: begin
                    op1_nxt    = inst_addr_i;  // link = pc + 4
                    op2_nxt    = 64'd4;
                    rd_nxt     = inst_i.j_fmt.rd;
                    wen_nxt    = 1'b1;
                    base_nxt   = inst_addr_i;
                    offset_nxt = imm_j_i;
                end
                id_pkg::OPC_JALR: begin
                    rs1_addr_o = inst_i.i_fmt.rs1;
                    op1_nxt    = inst_addr_i;
                    op2_nxt    = 64'd4;
                    rd_nxt     = inst_i.i_fmt.rd;
                    wen_nxt    = 1'b1;
                    base_nxt   = rs1_data_i;
                    offset_nxt = imm_i_i;
                end
                id_pkg::OPC_LUI: begin
                    op2_nxt = imm_u_i;
                    rd_nxt  = inst_i.u_fmt.rd;
                    wen_nxt = 1'b1;
                end
                id_pkg::OPC_AUIPC: begin
                    op1_nxt    = inst_addr_i;
                    op2_nxt    = imm_u_i;
                    rd_nxt     = inst_i.u_fmt.rd;
                    wen_nxt    = 1'b1;
                    offset_nxt = imm_u_i;
                end
                default: ;
            endcase
        end
    end

    // payload only moves on a valid instruction
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_valid_o       <= 1'b0;
            ex_reg_wen_o     <= 1'b0;
            ex_inst_addr_o   <= '0;
            ex_op1_o         <= '0;
            ex_op2_o         <= '0;
            ex_rd_addr_o     <= '0;
            ex_base_addr_o   <= '0;
            ex_offset_addr_o <= '0;
        end else begin
            ex_valid_o   <= inst_valid_i;
            ex_reg_wen_o <= inst_valid_i && wen_nxt;
            if (inst_valid_i) begin
                ex_inst_addr_o   <= inst_addr_i;
                ex_op1_o         <= op1_nxt;
                ex_op2_o         <= op2_nxt;
                ex_rd_addr_o     <= rd_nxt;
                ex_base_addr_o   <= base_nxt;
                ex_offset_addr_o <= offset_nxt;
            end
        end
    end

    // a bubble must never write back in a later stage
    a_wen_needs_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        !ex_valid_o |-> !ex_reg_wen_o)
        else $error("inst_decode: write enable set on an invalid slot");

endmodule

// ==== hw/id_stage.sv ====
module id_stage (
    input  logic                        clk,
    input  logic                        rst_n_i,

    input  logic                        inst_valid_i,
    input  logic [31:0]                 inst_i,
    input  logic [id_pkg::XLEN-1:0]     inst_addr_i,

    // write-back port
    input  logic                        wb_wen_i,
    input  logic [id_pkg::REG_AW-1:0]   wb_addr_i,
    input  logic [id_pkg::XLEN-1:0]     wb_data_i,

    output logic                        ex_valid_o,
    output logic [id_pkg::XLEN-1:0]     ex_inst_addr_o,
    output logic [id_pkg::XLEN-1:0]     ex_op1_o,
    output logic [id_pkg::XLEN-1:0]     ex_op2_o,
    output logic [id_pkg::REG_AW-1:0]   ex_rd_addr_o,
    output logic                        ex_reg_wen_o,
    output logic [id_pkg::XLEN-1:0]     ex_base_addr_o,
    output logic [id_pkg::XLEN-1:0]     ex_offset_addr_o
);

    logic [id_pkg::XLEN-1:0]    imm_i;
    logic [id_pkg::XLEN-1:0]    imm_s;
    logic [id_pkg::XLEN-1:0]    imm_b;
    logic [id_pkg::XLEN-1:0]    imm_u;
    logic [id_pkg::XLEN-1:0]    imm_j;
    logic [id_pkg::SHAMT_W-1:0] shamt;

    logic [id_pkg::REG_AW-1:0]  rs1_addr;
    logic [id_pkg::REG_AW-1:0]  rs2_addr;
    logic [id_pkg::XLEN-1:0]    rs1_data;
    logic [id_pkg::XLEN-1:0]    rs2_data;

    imm_gen u_imm_gen (
        .inst_i  (inst_i),
        .imm_i_o (imm_i),
        .imm_s_o (imm_s),
        .imm_b_o (imm_b),
        .imm_u_o (imm_u),
        .imm_j_o (imm_j),
        .shamt_o (shamt)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_wen_i   (wb_wen_i),
        .wb_addr_i  (wb_addr_i),
        .wb_data_i  (wb_data_i)
    );

    inst_decode u_inst_decode (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .inst_valid_i     (inst_valid_i),
        .inst_i           (inst_i),
        .inst_addr_i      (inst_addr_i),
        .imm_i_i          (imm_i),
        .imm_s_i          (imm_s),
        .imm_b_i          (imm_b),
        .imm_u_i          (imm_u),
        .imm_j_i          (imm_j),
        .shamt_i          (shamt),
        .rs1_data_i       (rs1_data),
        .rs2_data_i       (rs2_data),
        .rs1_addr_o       (rs1_addr),
        .rs2_addr_o       (rs2_addr),
        .ex_valid_o       (ex_valid_o),
        .ex_inst_addr_o   (ex_inst_addr_o),
        .ex_op1_o         (ex_op1_o),
        .ex_op2_o         (ex_op2_o),
        .ex_rd_addr_o     (ex_rd_addr_o),
        .ex_reg_wen_o     (ex_reg_wen_o),
        .ex_base_addr_o   (ex_base_addr_o),
        .ex_offset_addr_o (ex_offset_addr_o)
    );

endmodule

// ==== sim/tb_id_stage.sv ====
module tb_id_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int VALID_TIMEOUT = 16;  // cycles

    logic        clk = 1'b0;
    logic        rst_n_i;
    logic        inst_valid_i;
    logic [31:0] inst_i;
    logic [63:0] inst_addr_i;
    logic        wb_wen_i;
    logic [4:0]  wb_addr_i;
    logic [63:0] wb_data_i;
    logic        ex_valid_o;
    logic [63:0] ex_inst_addr_o;
    logic [63:0] ex_op1_o;
    logic [63:0] ex_op2_o;
    logic [4:0]  ex_rd_addr_o;
    logic        ex_reg_wen_o;
    logic [63:0] ex_base_addr_o;
    logic [63:0] ex_offset_addr_o;

    logic [31:0] lfsr = 32'haa03;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    bit          hung = 1'b0;
    logic [63:0] cur_pc = '0;
    logic [63:0] val_a = '0;       // contents of x3
    logic [63:0] val_b = '0;       // contents of x7
    logic        pend_wen = 1'b0;  // write-back that goes out with the next instruction
    logic [4:0]  pend_addr = '0;
    logic [63:0] pend_data = '0;

    id_stage dut_i (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .inst_valid_i     (inst_valid_i),
        .inst_i           (inst_i),
        .inst_addr_i      (inst_addr_i),
        .wb_wen_i         (wb_wen_i),
        .wb_addr_i        (wb_addr_i),
        .wb_data_i        (wb_data_i),
        .ex_valid_o       (ex_valid_o),
        .ex_inst_addr_o   (ex_inst_addr_o),
        .ex_op1_o         (ex_op1_o),
        .ex_op2_o         (ex_op2_o),
        .ex_rd_addr_o     (ex_rd_addr_o),
        .ex_reg_wen_o     (ex_reg_wen_o),
        .ex_base_addr_o   (ex_base_addr_o),
        .ex_offset_addr_o (ex_offset_addr_o)
    );

    always #20 clk = ~clk;

    always @(posedge hung) begin
        $display("TEST FAILED");
        $finish;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [63:0] sext(input logic [63:0] v, input int bits);
        logic signed [63:0] t;
        t = v << (64 - bits);
        return t >>> (64 - bits);
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [6:0] opc);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], id_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, id_pkg::OPC_JAL};
    endfunction

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [63:0] data);
        @(posedge clk);
        wb_wen_i  <= 1'b1;
        wb_addr_i <= addr;
        wb_data_i <= data;
        @(posedge clk);
        wb_wen_i <= 1'b0;
    endtask

    // one valid cycle, then wait for the id/ex slot
    task automatic issue(input logic [31:0] word, input logic [63:0] pc);
        int cnt;
        @(posedge clk);
        inst_valid_i <= 1'b1;
        inst_i       <= word;
        inst_addr_i  <= pc;
        wb_wen_i     <= pend_wen;
        wb_addr_i    <= pend_addr;
        wb_data_i    <= pend_data;
        pend_wen     = 1'b0;
        cur_pc       = pc;
        @(posedge clk);
        inst_valid_i <= 1'b0;
        wb_wen_i     <= 1'b0;
        cnt = 0;
        @(negedge clk);
        while (!ex_valid_o && cnt < VALID_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!ex_valid_o) begin
            $display("timeout: ex_valid_o still low %0d cycles after an instruction", cnt + 1);
            hung = 1'b1;
            forever @(negedge clk);
        end
    endtask

    task automatic expect_out(input logic [63:0] op1, input logic [63:0] op2,
                              input logic [4:0] rd, input logic wen,
                              input logic [63:0] base, input logic [63:0] offset);
        check("ex_inst_addr_o", ex_inst_addr_o, cur_pc);
        check("ex_op1_o", ex_op1_o, op1);
        check("ex_op2_o", ex_op2_o, op2);
        check("ex_rd_addr_o", 64'(ex_rd_addr_o), 64'(rd));
        check("ex_reg_wen_o", 64'(ex_reg_wen_o), 64'(wen));
        check("ex_base_addr_o", ex_base_addr_o, base);
        check("ex_offset_addr_o", ex_offset_addr_o, offset);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d mismatches", name, errors - errors_before);
        end
    endtask

    task automatic test_reset_idle();
        int e0;
        e0 = errors;
        @(negedge clk);
        check("ex_valid_o after reset", 64'(ex_valid_o), 64'd0);
        check("ex_reg_wen_o after reset", 64'(ex_reg_wen_o), 64'd0);
        check("ex_inst_addr_o after reset", ex_inst_addr_o, 64'd0);
        check("ex_op1_o after reset", ex_op1_o, 64'd0);
        check("ex_op2_o after reset", ex_op2_o, 64'd0);
        check("ex_rd_addr_o after reset", 64'(ex_rd_addr_o), 64'd0);
        check("ex_base_addr_o after reset", ex_base_addr_o, 64'd0);
        check("ex_offset_addr_o after reset", ex_offset_addr_o, 64'd0);
        repeat (3) begin
            @(negedge clk);
            check("ex_valid_o idle", 64'(ex_valid_o), 64'd0);
            check("ex_reg_wen_o idle", 64'(ex_reg_wen_o), 64'd0);
        end
        finish_test("reset and idle", e0);
    endtask

    task automatic test_reg_ops();
        int e0;
        logic [63:0] sh6;
        e0 = errors;
        val_a = rand_bits(64);
        val_b = rand_bits(64);
        sh6 = {58'd0, val_b[5:0]};  // shifts only see rs2[5:0]
        write_reg(5'd3, val_a);
        write_reg(5'd7, val_b);
        issue(enc_r(7'b0000000, 5'd7, 5'd3, 3'b000, 5'd10, id_pkg::OPC_OP), 64'h1000);
        expect_out(val_a, val_b, 5'd10, 1'b1, 64'd0, 64'd0);
        issue(enc_r(7'b0000000, 5'd7, 5'd3, 3'b000, 5'd11, id_pkg::OPC_OP_W), 64'h1004);
        expect_out(val_a, val_b, 5'd11, 1'b1, 64'd0, 64'd0);
        issue(enc_r(7'b0000001, 5'd7, 5'd3, 3'b000, 5'd12, id_pkg::OPC_OP), 64'h1008);
        expect_out(val_a, val_b, 5'd12, 1'b1, 64'd0, 64'd0);
        issue(enc_r(7'b0000000, 5'd7, 5'd3, 3'b001, 5'd13, id_pkg::OPC_OP), 64'h100c);
        expect_out(val_a, sh6, 5'd13, 1'b1, 64'd0, 64'd0);
        issue(enc_r(7'b0100000, 5'd7, 5'd3, 3'b101, 5'd13, id_pkg::OPC_OP), 64'h1010);
        expect_out(val_a, sh6, 5'd13, 1'b1, 64'd0, 64'd0);
        issue(enc_r(7'b0000000, 5'd7, 5'd3, 3'b101, 5'd13, id_pkg::OPC_OP_W), 64'h1014);
        expect_out(val_a, sh6, 5'd13, 1'b1, 64'd0, 64'd0);
        issue(enc_r(7'b0000001, 5'd7, 5'd3, 3'b101, 5'd14, id_pkg::OPC_OP), 64'h1018);  // divu
        expect_out(val_a, val_b, 5'd14, 1'b1, 64'd0, 64'd0);
        finish_test("register ops", e0);
    endtask

    task automatic test_imm_ops();
        int e0;
        logic [11:0] imm;
        logic [5:0]  sh;
        e0 = errors;
        imm = 12'(rand_bits(12));
        issue(enc_i(imm, 5'd3, 3'b000, 5'd15, id_pkg::OPC_OP_IMM), 64'h2000);
        expect_out(val_a, sext(64'(imm), 12), 5'd15, 1'b1, 64'd0, 64'd0);
        imm = 12'(rand_bits(12));
        issue(enc_i(imm, 5'd7, 3'b111, 5'd16, id_pkg::OPC_OP_IMM), 64'h2004);
        expect_out(val_b, sext(64'(imm), 12), 5'd16, 1'b1, 64'd0, 64'd0);
        imm = 12'(rand_bits(12));
        issue(enc_i(imm, 5'd3, 3'b000, 5'd17, id_pkg::OPC_OP_IMM_W), 64'h2008);
        expect_out(val_a, sext(64'(imm), 12), 5'd17, 1'b1, 64'd0, 64'd0);
        sh = 6'(rand_bits(6));
        issue(enc_i({6'b000000, sh}, 5'd3, 3'b001, 5'd18, id_pkg::OPC_OP_IMM), 64'h200c);
        expect_out(val_a, {58'd0, sh}, 5'd18, 1'b1, 64'd0, 64'd0);
        sh = 6'(rand_bits(6));
        issue(enc_i({6'b010000, sh}, 5'd7, 3'b101, 5'd19, id_pkg::OPC_OP_IMM), 64'h2010);
        expect_out(val_b, {58'd0, sh}, 5'd19, 1'b1, 64'd0, 64'd0);
        finish_test("immediate ops", e0);
    endtask

    task automatic test_mem_branch();
        int e0;
        logic [63:0] pc;
        logic [11:0] imm;
        logic [12:0] boff;
        e0 = errors;
        pc = rand_bits(64);
        imm = 12'(rand_bits(12));
        issue(enc_i(imm, 5'd3, 3'b011, 5'd20, id_pkg::OPC_LOAD), pc);  // ld
        expect_out(val_a, sext(64'(imm), 12), 5'd20, 1'b1, val_a, sext(64'(imm), 12));
        imm = 12'(rand_bits(12));
        issue(enc_s(imm, 5'd7, 5'd3, 3'b011, id_pkg::OPC_STORE), pc);  // sd
        expect_out(64'd0, val_b, 5'd0, 1'b0, val_a, sext(64'(imm), 12));
        imm = 12'(rand_bits(12));
        issue(enc_s(imm, 5'd3, 5'd7, 3'b000, id_pkg::OPC_STORE), pc);  // sb
        expect_out(64'd0, val_a, 5'd0, 1'b0, val_b, sext(64'(imm), 12));
        boff = {12'(rand_bits(12)), 1'b0};
        issue(enc_b(boff, 5'd7, 5'd3, 3'b001), pc);  // bne
        expect_out(val_a, val_b, 5'd0, 1'b0, pc, sext(64'(boff), 13));
        finish_test("loads stores branches", e0);
    endtask

    task automatic test_jumps();
        int e0;
        logic [63:0] pc;
        logic [11:0] imm;
        logic [20:0] joff;
        logic [19:0] upper;
        logic [63:0] uimm;
        e0 = errors;
        pc = rand_bits(64);
        joff = {20'(rand_bits(20)), 1'b0};
        issue(enc_j(joff, 5'd1), pc);
        expect_out(pc, 64'd4, 5'd1, 1'b1, pc, sext(64'(joff), 21));
        imm = 12'(rand_bits(12));
        issue(enc_i(imm, 5'd3, 3'b000, 5'd1, id_pkg::OPC_JALR), pc);
        expect_out(pc, 64'd4, 5'd1, 1'b1, val_a, sext(64'(imm), 12));
        upper = 20'(rand_bits(20));
        uimm = sext({32'd0, upper, 12'd0}, 32);
        issue(enc_u(upper, 5'd21, id_pkg::OPC_LUI), pc);
        expect_out(64'd0, uimm, 5'd21, 1'b1, 64'd0, 64'd0);
        issue(enc_u(upper, 5'd22, id_pkg::OPC_AUIPC), pc);
        expect_out(pc, uimm, 5'd22, 1'b1, 64'd0, uimm);
        finish_test("jumps and upper immediates", e0);
    endtask

    task automatic test_edges();
        int e0;
        logic [63:0] fresh;
        logic [24:0] junk;
        e0 = errors;
        write_reg(5'd0, rand_bits(64));
        issue(enc_r(7'b0000000, 5'd7, 5'd0, 3'b000, 5'd23, id_pkg::OPC_OP), 64'h3000);
        expect_out(64'd0, val_b, 5'd23, 1'b1, 64'd0, 64'd0);
        fresh = rand_bits(64);
        pend_wen  = 1'b1;  // x9 written in the decode cycle
        pend_addr = 5'd9;
        pend_data = fresh;
        issue(enc_r(7'b0000000, 5'd9, 5'd9, 3'b000, 5'd24, id_pkg::OPC_OP), 64'h3004);
        expect_out(fresh, fresh, 5'd24, 1'b1, 64'd0, 64'd0);
        junk = 25'(rand_bits(25));
        issue({junk, 7'b1111111}, 64'h3008);
        check("ex_valid_o on unknown opcode", 64'(ex_valid_o), 64'd1);
        expect_out(64'd0, 64'd0, 5'd0, 1'b0, 64'd0, 64'd0);
        issue(enc_s(12'h7ff, 5'd7, 5'd3, 3'b111, id_pkg::OPC_STORE), 64'h300c);  // bad func3
        expect_out(64'd0, 64'd0, 5'd0, 1'b0, 64'd0, 64'd0);
        finish_test("edge cases", e0);
    endtask

    initial begin
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        inst_addr_i  = '0;
        wb_wen_i     = 1'b0;
        wb_addr_i    = '0;
        wb_data_i    = '0;
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        test_reset_idle();
        test_reg_ops();
        test_imm_ops();
        test_mem_branch();
        test_jumps();
        test_edges();
        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
hw/id_pkg.sv
hw/imm_gen.sv
hw/reg_file.sv
hw/inst_decode.sv
hw/id_stage.sv
sim/tb_id_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	status=$$?; \
	echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
